// ==== flist.f ====
+incdir+sim
source/cfs_pkg.sv
source/cfs_apb_regs.sv
source/cfs_cmd_sched.sv
source/cfs_sample_timer.sv
source/cfs_phase_accum.sv
source/cfs_cordic_rotator.sv
source/cfs_scale_round.sv
source/cfs_top.sv
sim/cfs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module cfs_tb -f flist.f -o cfs_sim \
  && ./obj_dir/cfs_sim \
  || { echo "simulation build or run failed"; exit 1; }

// ==== sim/cfs_tb_model.svh ====
//************************************************
// Reference model, bit exact for ITER stages up to 16
// Needs ITER, report_failure and cfs_pkg from the includer
//************************************************
`ifndef CFS_TB_MODEL_SVH
`define CFS_TB_MODEL_SVH

logic [31:0] lfsr_state = 32'ha564bbb9;

// Reference NCO and timed command state
logic [31:0]              m_acc;
logic [31:0]              m_inc;
logic [CFS_SCALE_W-1:0]   m_scale;
logic [31:0]              m_tfreq_reg;
logic [31:0]              m_cmd_tfreq;
logic [31:0]              m_ttime;
logic [31:0]              m_count;
logic                     m_pending;
logic [31:0]              exp_q[$];

// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        fb;
  int          b;
  v = '0;
  for (b = 0; b < n; b++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    v          = {v[30:0], fb};
  end
  return v;
endfunction

// atan(2**-k) as a fraction of a full turn, in 2**20 units
function automatic int atan_units(input int k);
  real turn_frac;
  turn_frac = $atan(1.0 / (2.0 ** k)) / (2.0 * 3.141592653589793);
  return $rtoi(turn_frac * 1048576.0 + 0.5);
endfunction

function automatic logic [15:0] round_sat16(input longint p);
  longint r;
  r = (p + 64'sd32768) >>> 16;
  if (r > 32767) begin
    return 16'h7fff;
  end else if (r < -32768) begin
    return 16'h8000;
  end
  return r[15:0];
endfunction

// Sample times e^(+j*phase), then gain, rounding and saturation
function automatic cfs_sample_u ref_output(input logic [19:0] phase, input cfs_sample_u s,
                                           input logic [CFS_SCALE_W-1:0] scale);
  int          in_i;
  int          in_q;
  int          x;
  int          y;
  int          z;
  int          xn;
  int          yn;
  int          k;
  cfs_sample_u r;
  in_i = $signed(s.iq[1]);
  in_q = $signed(s.iq[0]);
  case (phase[19:18])
    2'd0: begin
      x = in_i;
      y = in_q;
    end
    2'd1: begin
      x = -in_q;
      y = in_i;
    end
    2'd2: begin
      x = -in_i;
      y = -in_q;
    end
    default: begin
      x = in_q;
      y = -in_i;
    end
  endcase
  z = int'(phase[17:0]);
  for (k = 0; k < ITER; k++) begin
    if (z >= 0) begin
      xn = x - (y >>> k);
      yn = y + (x >>> k);
      z  = z - atan_units(k);
    end else begin
      xn = x + (y >>> k);
      yn = y - (x >>> k);
      z  = z + atan_units(k);
    end
    x = xn;
    y = yn;
  end
  r.iq[1] = round_sat16(longint'(x) * longint'(scale));
  r.iq[0] = round_sat16(longint'(y) * longint'(scale));
  return r;
endfunction

// One accepted sample, phase is the sum before this accept
task automatic model_accept(input cfs_sample_u s);
  cfs_sample_u e;
  logic [31:0] eff;
  e   = ref_output(m_acc[31:12], s, m_scale);
  exp_q.push_back(e.raw);
  eff = m_inc;
  if (m_pending && (m_count >= m_ttime)) begin
    m_pending = 1'b0;
    m_inc     = m_cmd_tfreq;
    eff       = m_cmd_tfreq;
  end
  m_acc   = m_acc + eff;
  m_count = m_count + 32'd1;
endtask

task automatic check_value(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
  if (exp_v !== act_v) begin
    report_failure($sformatf("Fail %s: expected %h, actual %h", name, exp_v, act_v));
  end
endtask

`endif

// ==== sim/cfs_tb.sv ====
//************************************************
// Testbench for cfs_top with 16 CORDIC stages
// Registers are written only while the stream is idle
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_tb;
  import cfs_pkg::*;

  localparam int                     ITER          = 16;
  localparam logic [CFS_SCALE_W-1:0] RESET_SCALE   = 18'd39797;
  localparam int                     APB_TIMEOUT   = 16;
  localparam int                     DRAIN_TIMEOUT = 20000;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_psel;
  logic                  i_penable;
  logic                  i_pwrite;
  logic [CFS_APB_AW-1:0] i_paddr;
  logic [31:0]           i_pwdata;
  logic [31:0]           o_prdata;
  logic                  o_pready;
  logic                  o_pslverr;
  cfs_sample_u           i_in_data;
  logic                  i_in_valid;
  logic                  o_in_ready;
  cfs_sample_u           o_out_data;
  logic                  o_out_valid;
  logic                  i_out_ready;

  logic                  in_taken;
  logic                  stall_mode;
  logic                  gap_mode;
  int                    out_count;
  string                 test_name;
  cfs_sample_u           send_q[$];

  `include "cfs_tb_model.svh"

  cfs_top #(.ITERATIONS(ITER), .RESET_SCALE(RESET_SCALE)) dut_i (
    .clk, .i_rst_n, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
    .o_prdata, .o_pready, .o_pslverr,
    .i_in_data, .i_in_valid, .o_in_ready,
    .o_out_data, .o_out_valid, .i_out_ready);

  always #2 clk = ~clk;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped on first error");
  endtask

  // Input valid holds until accepted, random gaps and output stalls
  always @(negedge clk) begin
    if (send_q.size() > 0 || i_in_valid || exp_q.size() > 0) begin
      if (!i_in_valid || in_taken) begin
        in_taken = 1'b0;
        if (send_q.size() > 0 && (!gap_mode || rand_bits(1) == 32'd1)) begin
          i_in_data  = send_q.pop_front();
          i_in_valid = 1'b1;
        end else begin
          i_in_valid = 1'b0;
        end
      end
      i_out_ready = !stall_mode || (rand_bits(2) != 32'd0);
    end else begin
      i_out_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (i_rst_n && i_in_valid && o_in_ready) begin
      in_taken = 1'b1;
      model_accept(i_in_data);
    end
  end

  // Output checker, in order against the expected queue
  always @(posedge clk) begin
    if (i_rst_n && o_out_valid && i_out_ready) begin
      if (exp_q.size() == 0) begin
        report_failure("DUT sent an output sample that was never expected");
      end else begin
        check_value($sformatf("%s sample %0d", test_name, out_count), exp_q.pop_front(),
                    o_out_data.raw);
        out_count++;
      end
    end
  end

  task automatic apb_xfer(input logic wr, input logic [CFS_APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waits;
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(negedge clk);
    i_penable = 1'b1;
    waits     = 0;
    @(posedge clk);
    while (!o_pready) begin
      waits++;
      if (waits > APB_TIMEOUT) begin
        report_failure("APB transfer never saw pready");
      end
      @(posedge clk);
    end
    rdata = o_prdata;
    err   = o_pslverr;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [CFS_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_value($sformatf("%s pslverr on write %h", test_name, addr), 32'd0, 32'(err));
    case (addr)
      CFS_REG_FREQ:  m_inc = data;
      CFS_REG_SCALE: m_scale = data[CFS_SCALE_W-1:0];
      CFS_REG_TFREQ: m_tfreq_reg = data;
      CFS_REG_TTIME: begin
        m_cmd_tfreq = m_tfreq_reg;
        m_ttime     = data;
        m_pending   = 1'b1;
      end
      default: ;
    endcase
  endtask

  task automatic reg_read(input logic [CFS_APB_AW-1:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check_value($sformatf("%s pslverr on read %h", test_name, addr), 32'd0, 32'(err));
  endtask

  task automatic expect_error(input logic [CFS_APB_AW-1:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, 32'h1234_5678, rd, err);
    check_value($sformatf("%s pslverr on write %h", test_name, addr), 32'd1, 32'(err));
  endtask

  task automatic queue_samples(input int n, input logic full_scale);
    cfs_sample_u s;
    int          idx;
    for (idx = 0; idx < n; idx++) begin
      s.raw = rand_bits(32);
      if (full_scale) begin
        s.iq[1] = s.iq[1][0] ? 16'h7fff : 16'h8000;
        s.iq[0] = s.iq[0][0] ? 16'h7fff : 16'h8000;
      end
      send_q.push_back(s);
    end
  endtask

  // Ends on a rising edge once every sample is in and checked
  task automatic drain();
    int cycles;
    cycles = 0;
    while (send_q.size() != 0 || i_in_valid || exp_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        report_failure($sformatf("%s: stream did not drain in time", test_name));
      end
    end
  endtask

  initial begin
    logic [31:0] rd;
    int          seg;
    clk         = 1'b0;
    i_rst_n     = 1'b0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_in_data   = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b1;
    in_taken    = 1'b0;
    stall_mode  = 1'b0;
    gap_mode    = 1'b0;
    out_count   = 0;
    test_name   = "regs";
    m_acc       = '0;
    m_inc       = '0;
    m_scale     = RESET_SCALE;
    m_tfreq_reg = '0;
    m_cmd_tfreq = '0;
    m_ttime     = '0;
    m_count     = '0;
    m_pending   = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    reg_read(CFS_REG_SCALE, rd);
    check_value("regs scale after reset", 32'(RESET_SCALE), rd);
    reg_read(CFS_REG_COUNT, rd);
    check_value("regs count after reset", 32'd0, rd);
    expect_error(8'h20);
    expect_error(CFS_REG_COUNT);
    expect_error(CFS_REG_STATUS);

    // Phase stays zero, output is the raw CORDIC gain
    test_name = "zero_freq";
    reg_write(CFS_REG_SCALE, 32'd65536);
    queue_samples(64, 1'b0);
    drain();

    test_name = "rand_freq";
    for (seg = 0; seg < 6; seg++) begin
      reg_write(CFS_REG_FREQ, rand_bits(32));
      reg_write(CFS_REG_SCALE, rand_bits(CFS_SCALE_W));
      queue_samples(48, 1'b0);
      drain();
    end
    reg_read(CFS_REG_FREQ, rd);
    check_value("rand_freq freq readback", m_inc, rd);

    test_name = "saturate";
    reg_write(CFS_REG_SCALE, 32'h3ffff);
    queue_samples(32, 1'b1);
    drain();

    test_name  = "backpressure";
    stall_mode = 1'b1;
    gap_mode   = 1'b1;
    reg_write(CFS_REG_FREQ, rand_bits(32));
    reg_write(CFS_REG_SCALE, 32'd65536);
    queue_samples(200, 1'b0);
    drain();

    // Command lands on sample T, 20 samples ahead
    test_name = "timed";
    reg_read(CFS_REG_COUNT, rd);
    check_value("timed count before", m_count, rd);
    reg_write(CFS_REG_FREQ, rand_bits(32));
    reg_write(CFS_REG_TFREQ, rand_bits(32));
    reg_write(CFS_REG_TTIME, m_count + 32'd20);
    reg_read(CFS_REG_STATUS, rd);
    check_value("timed status pending", 32'h1, rd);
    queue_samples(40, 1'b0);
    drain();
    reg_read(CFS_REG_STATUS, rd);
    check_value("timed status done", 32'h0, rd);
    reg_read(CFS_REG_COUNT, rd);
    check_value("timed count after", m_count, rd);

    test_name = "late";
    reg_write(CFS_REG_TFREQ, rand_bits(32));
    reg_write(CFS_REG_TTIME, 32'd5);
    reg_read(CFS_REG_STATUS, rd);
    check_value("late status pending", 32'h1, rd);
    queue_samples(8, 1'b0);
    drain();
    reg_read(CFS_REG_STATUS, rd);
    check_value("late status set", 32'h2, rd);
    reg_read(CFS_REG_STATUS, rd);
    check_value("late status cleared", 32'h0, rd);

    if (exp_q.size() == 0 && out_count == int'(m_count)) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_failure("stream ended with output samples missing");
    end
  end

endmodule

`default_nettype wire

// ==== source/cfs_apb_regs.sv ====
//************************************************
// APB slave, pready always high, no wait states
// Writes to STATUS/COUNT or unmapped addresses error
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_apb_regs #(
  parameter logic [cfs_pkg::CFS_SCALE_W-1:0] RESET_SCALE = 18'd39797
) (
  input  wire                                   clk,
  input  wire                                   i_rst_n,
  input  wire                                   i_psel,
  input  wire                                   i_penable,
  input  wire                                   i_pwrite,
  input  wire  [cfs_pkg::CFS_APB_AW-1:0]        i_paddr,
  input  wire  [31:0]                           i_pwdata,
  input  wire                                   i_pending,
  input  wire                                   i_late,
  input  wire  [cfs_pkg::CFS_TIME_W-1:0]        i_count,
  output logic [31:0]                           o_prdata,
  output logic                                  o_pready,
  output logic                                  o_pslverr,
  output logic                                  o_freq_wr,
  output logic [cfs_pkg::CFS_PHASE_ACC_W-1:0]   o_freq,
  output logic [cfs_pkg::CFS_SCALE_W-1:0]       o_scale,
  output logic                                  o_arm,
  output logic [cfs_pkg::CFS_PHASE_ACC_W-1:0]   o_tfreq,
  output logic [cfs_pkg::CFS_TIME_W-1:0]        o_ttime
);
  import cfs_pkg::*;

  logic [CFS_PHASE_ACC_W-1:0] freq_q;
  logic [CFS_SCALE_W-1:0]     scale_q;
  logic [CFS_PHASE_ACC_W-1:0] tfreq_q;
  logic [CFS_TIME_W-1:0]      ttime_q;
  logic                       late_q;
  logic                       mapped;
  logic                       read_only;
  logic                       access;
  logic                       wr_en;
  logic                       rd_status;

  always_comb begin
    o_prdata  = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    case (i_paddr)
      CFS_REG_FREQ:  o_prdata = freq_q;
      CFS_REG_SCALE: o_prdata = 32'(scale_q);
      CFS_REG_TFREQ: o_prdata = tfreq_q;
      CFS_REG_TTIME: o_prdata = ttime_q;
      CFS_REG_STATUS: begin
        o_prdata  = {30'd0, late_q, i_pending};
        read_only = 1'b1;
      end
      CFS_REG_COUNT: begin
        o_prdata  = i_count;
        read_only = 1'b1;
      end
      default: mapped = 1'b0;
    endcase
  end

  assign access    = i_psel && i_penable;
  assign o_pready  = 1'b1;
  assign o_pslverr = access && (!mapped || (i_pwrite && read_only));
  assign wr_en     = access && i_pwrite && !o_pslverr;
  assign rd_status = access && !i_pwrite && (i_paddr == CFS_REG_STATUS);

  // Strobes fire in the access cycle so the new value lands on its closing edge
  assign o_freq_wr = wr_en && (i_paddr == CFS_REG_FREQ);
  assign o_freq    = i_pwdata;
  assign o_arm     = wr_en && (i_paddr == CFS_REG_TTIME);
  assign o_ttime   = i_pwdata;
  assign o_tfreq   = tfreq_q;
  assign o_scale   = scale_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      scale_q <= RESET_SCALE;
      late_q  <= 1'b0;
    end else begin
      if (wr_en && (i_paddr == CFS_REG_SCALE)) begin
        scale_q <= i_pwdata[CFS_SCALE_W-1:0];
      end
      // A new late event wins over a clearing read
      if (i_late) begin
        late_q <= 1'b1;
      end else if (rd_status) begin
        late_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_freq_wr) freq_q <= i_pwdata;
    if (wr_en && (i_paddr == CFS_REG_TFREQ)) tfreq_q <= i_pwdata;
    if (o_arm) ttime_q <= i_pwdata;
  end

  a_strobe_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(o_arm && o_freq_wr));

endmodule

`default_nettype wire

// ==== source/cfs_cmd_sched.sv ====
//************************************************
// Single pending timed command, a re-arm replaces it
// Apply is combinational on the accept of sample T
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_cmd_sched (
  input  wire                                   clk,
  input  wire                                   i_rst_n,
  input  wire                                   i_arm,
  input  wire  [cfs_pkg::CFS_PHASE_ACC_W-1:0]   i_tfreq,
  input  wire  [cfs_pkg::CFS_TIME_W-1:0]        i_ttime,
  input  wire                                   i_accept,
  input  wire                                   i_hit,
  input  wire                                   i_late,
  output logic [cfs_pkg::CFS_TIME_W-1:0]        o_cmd_time,
  output logic                                  o_apply,
  output logic [cfs_pkg::CFS_PHASE_ACC_W-1:0]   o_tfreq_q,
  output logic                                  o_pending,
  output logic                                  o_late_evt
);
  import cfs_pkg::*;

  localparam logic ST_IDLE  = 1'b0;
  localparam logic ST_ARMED = 1'b1;

  logic                       state_q;
  logic [CFS_PHASE_ACC_W-1:0] tfreq_q;
  logic [CFS_TIME_W-1:0]      time_q;
  logic                       fire;

  // Late covers a target already passed when the command was armed
  assign fire = (state_q == ST_ARMED) && i_accept && (i_hit || i_late);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else if (i_arm) begin
      state_q <= ST_ARMED;
    end else if (fire) begin
      state_q <= ST_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (i_arm) begin
      tfreq_q <= i_tfreq;
      time_q  <= i_ttime;
    end
  end

  assign o_apply    = fire;
  assign o_late_evt = fire && i_late;
  assign o_pending  = (state_q == ST_ARMED);
  assign o_cmd_time = time_q;
  assign o_tfreq_q  = tfreq_q;

  a_apply_armed: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_apply && !i_arm |=> !o_pending);

endmodule

`default_nettype wire

// ==== source/cfs_cordic_rotator.sv ====
//************************************************
// Rotates I/Q by +phase, ITERATIONS from 8 to 16
// Output carries the CORDIC gain of about 1.6468
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_cordic_rotator #(
  parameter int ITERATIONS = 16
) (
  input  wire                                      clk,
  input  wire                                      i_rst_n,
  input  wire                                      i_advance,
  input  wire                                      i_valid,
  input  wire  cfs_pkg::cfs_sample_u               i_sample,
  input  wire  [cfs_pkg::CFS_PHASE_W-1:0]          i_phase,
  output logic                                     o_valid,
  output logic signed [cfs_pkg::CFS_CORDIC_W-1:0]  o_i,
  output logic signed [cfs_pkg::CFS_CORDIC_W-1:0]  o_q
);
  import cfs_pkg::*;

  logic                           s0_valid;
  cfs_sample_u                    s0_sample;
  logic signed [CFS_CORDIC_W-1:0] ext_i;
  logic signed [CFS_CORDIC_W-1:0] ext_q;
  logic [ITERATIONS:0]            v_q;
  logic signed [CFS_CORDIC_W-1:0] x_q [0:ITERATIONS];
  logic signed [CFS_CORDIC_W-1:0] y_q [0:ITERATIONS];
  logic signed [CFS_PHASE_W-1:0]  z_q [0:ITERATIONS];

  // Valid shifts through every stage together
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s0_valid <= 1'b0;
      v_q      <= '0;
    end else if (i_advance) begin
      s0_valid <= i_valid;
      v_q      <= {v_q[ITERATIONS-1:0], s0_valid};
    end
  end

  // Sample waits one cycle for the phase register
  always_ff @(posedge clk) begin
    if (i_advance) begin
      s0_sample <= i_sample;
    end
  end

  assign ext_i = CFS_CORDIC_W'($signed(s0_sample.iq[1]));
  assign ext_q = CFS_CORDIC_W'($signed(s0_sample.iq[0]));

  // Exact quarter-turn by swap and negate
  always_ff @(posedge clk) begin
    if (i_advance) begin
      case (i_phase[CFS_PHASE_W-1 -: 2])
        2'd0: begin
          x_q[0] <= ext_i;
          y_q[0] <= ext_q;
        end
        2'd1: begin
          x_q[0] <= -ext_q;
          y_q[0] <= ext_i;
        end
        2'd2: begin
          x_q[0] <= -ext_i;
          y_q[0] <= -ext_q;
        end
        default: begin
          x_q[0] <= ext_q;
          y_q[0] <= -ext_i;
        end
      endcase
      z_q[0] <= {2'b00, i_phase[CFS_PHASE_W-3:0]};
    end
  end

  for (genvar k = 0; k < ITERATIONS; k++) begin : g_stage
    localparam logic signed [CFS_PHASE_W-1:0] ATAN = {2'b00, cfs_atan(k)};

    always_ff @(posedge clk) begin
      if (i_advance) begin
        // Turn toward zero residual angle
        if (z_q[k] >= 0) begin
          x_q[k+1] <= x_q[k] - (y_q[k] >>> k);
          y_q[k+1] <= y_q[k] + (x_q[k] >>> k);
          z_q[k+1] <= z_q[k] - ATAN;
        end else begin
          x_q[k+1] <= x_q[k] + (y_q[k] >>> k);
          y_q[k+1] <= y_q[k] - (x_q[k] >>> k);
          z_q[k+1] <= z_q[k] + ATAN;
        end
      end
    end
  end

  assign o_valid = v_q[ITERATIONS];
  assign o_i     = x_q[ITERATIONS];
  assign o_q     = y_q[ITERATIONS];

  a_valid_known: assert property (@(posedge clk)
    i_rst_n |-> !$isunknown({s0_valid, v_q}));

endmodule

`default_nettype wire

// ==== source/cfs_phase_accum.sv ====
//************************************************
// NCO, phase of sample n is the sum before its accept
// A FREQ write in the same cycle wins over apply
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_phase_accum (
  input  wire                                   clk,
  input  wire                                   i_rst_n,
  input  wire                                   i_accept,
  input  wire                                   i_freq_wr,
  input  wire  [cfs_pkg::CFS_PHASE_ACC_W-1:0]   i_freq,
  input  wire                                   i_apply,
  input  wire  [cfs_pkg::CFS_PHASE_ACC_W-1:0]   i_tfreq,
  output logic [cfs_pkg::CFS_PHASE_W-1:0]       o_phase
);
  import cfs_pkg::*;

  logic [CFS_PHASE_ACC_W-1:0] inc_q;
  logic [CFS_PHASE_ACC_W-1:0] acc_q;
  logic [CFS_PHASE_ACC_W-1:0] eff_inc;

  assign eff_inc = i_apply ? i_tfreq : inc_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      inc_q <= '0;
      acc_q <= '0;
    end else begin
      if (i_freq_wr) begin
        inc_q <= i_freq;
      end else if (i_apply) begin
        inc_q <= i_tfreq;
      end
      if (i_accept) begin
        acc_q <= acc_q + eff_inc;
      end
    end
  end

  // Phase register, first pipeline stage
  always_ff @(posedge clk) begin
    if (i_accept) begin
      o_phase <= acc_q[CFS_PHASE_ACC_W-1 -: CFS_PHASE_W];
    end
  end

endmodule

`default_nettype wire

// ==== source/cfs_pkg.sv ====
//************************************************
// Shared widths, APB register map and sample word
// Phase unit is 2*pi / 2**20, atan table for k = 0..15
//************************************************
`default_nettype none

package cfs_pkg;

  localparam int CFS_SAMPLE_W    = 16;
  // Four guard bits for CORDIC gain and quadrant swap
  localparam int CFS_CORDIC_W    = 20;
  localparam int CFS_PHASE_ACC_W = 32;
  // Top two bits select the quadrant
  localparam int CFS_PHASE_W     = 20;
  localparam int CFS_SCALE_W     = 18;
  localparam int CFS_SCALE_FRAC  = 16;
  localparam int CFS_TIME_W      = 32;
  localparam int CFS_APB_AW      = 8;

  localparam logic [CFS_APB_AW-1:0] CFS_REG_FREQ   = 8'h00;
  localparam logic [CFS_APB_AW-1:0] CFS_REG_SCALE  = 8'h04;
  localparam logic [CFS_APB_AW-1:0] CFS_REG_TFREQ  = 8'h08;
  localparam logic [CFS_APB_AW-1:0] CFS_REG_TTIME  = 8'h0C;
  localparam logic [CFS_APB_AW-1:0] CFS_REG_STATUS = 8'h10;
  localparam logic [CFS_APB_AW-1:0] CFS_REG_COUNT  = 8'h14;

  // Stream word, iq[1] is I and iq[0] is Q
  typedef union packed {
    logic [2*CFS_SAMPLE_W-1:0]    raw;
    logic [1:0][CFS_SAMPLE_W-1:0] iq;
  } cfs_sample_u;

  // atan(2**-k) in residual phase units, rounded
  function automatic logic [CFS_PHASE_W-3:0] cfs_atan(input int unsigned k);
    case (k)
      0:       return 18'd131072;
      1:       return 18'd77376;
      2:       return 18'd40884;
      3:       return 18'd20753;
      4:       return 18'd10417;
      5:       return 18'd5213;
      6:       return 18'd2607;
      7:       return 18'd1304;
      8:       return 18'd652;
      9:       return 18'd326;
      10:      return 18'd163;
      11:      return 18'd81;
      12:      return 18'd41;
      13:      return 18'd20;
      14:      return 18'd10;
      15:      return 18'd5;
      default: return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== source/cfs_sample_timer.sv ====
//************************************************
// Accepted sample counter, wraps at 2**32
// Late is an unsigned compare, no wrap handling
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_sample_timer (
  input  wire                              clk,
  input  wire                              i_rst_n,
  input  wire                              i_accept,
  input  wire  [cfs_pkg::CFS_TIME_W-1:0]   i_cmd_time,
  output logic [cfs_pkg::CFS_TIME_W-1:0]   o_count,
  output logic                             o_hit,
  output logic                             o_late
);
  import cfs_pkg::*;

  logic [CFS_TIME_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      count_q <= '0;
    end else if (i_accept) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Count is the index of the sample being accepted now
  assign o_count = count_q;
  assign o_hit   = (count_q == i_cmd_time);
  assign o_late  = (count_q > i_cmd_time);

endmodule

`default_nettype wire

// ==== source/cfs_scale_round.sv ====
//************************************************
// Gain in Q16, round half up, saturate to 16 bits
// Advance is the global stall for the whole pipeline
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_scale_round (
  input  wire                                      clk,
  input  wire                                      i_rst_n,
  input  wire                                      i_valid,
  input  wire  signed [cfs_pkg::CFS_CORDIC_W-1:0]  i_i,
  input  wire  signed [cfs_pkg::CFS_CORDIC_W-1:0]  i_q,
  input  wire  [cfs_pkg::CFS_SCALE_W-1:0]          i_scale,
  input  wire                                      i_ready,
  output logic                                     o_advance,
  output logic                                     o_valid,
  output cfs_pkg::cfs_sample_u                     o_data
);
  import cfs_pkg::*;

  localparam int PW = CFS_CORDIC_W + CFS_SCALE_W + 1;

  logic signed [PW-1:0] prod_i;
  logic signed [PW-1:0] prod_q;

  function automatic logic [CFS_SAMPLE_W-1:0] round_sat(input logic signed [PW-1:0] p);
    logic signed [PW-1:0] r;
    r = (p + (PW'(1) <<< (CFS_SCALE_FRAC - 1))) >>> CFS_SCALE_FRAC;
    if (r > 32767) begin
      return 16'h7FFF;
    end else if (r < -32768) begin
      return 16'h8000;
    end
    return r[CFS_SAMPLE_W-1:0];
  endfunction

  // Scale is unsigned, zero extend before the signed multiply
  assign prod_i = i_i * $signed({1'b0, i_scale});
  assign prod_q = i_q * $signed({1'b0, i_scale});

  assign o_advance = !o_valid || i_ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (o_advance) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_advance) begin
      o_data.iq[1] <= round_sat(prod_i);
      o_data.iq[0] <= round_sat(prod_q);
    end
  end

  a_hold_data: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

`default_nettype wire

// ==== source/cfs_top.sv ====
//************************************************
// Frequency shifter top, ITERATIONS + 3 cycle latency
// Only one timed frequency command can be pending
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cfs_top #(
  parameter int                              ITERATIONS  = 16,
  parameter logic [cfs_pkg::CFS_SCALE_W-1:0] RESET_SCALE = 18'd39797
) (
  input  wire                              clk,
  input  wire                              i_rst_n,
  input  wire                              i_psel,
  input  wire                              i_penable,
  input  wire                              i_pwrite,
  input  wire  [cfs_pkg::CFS_APB_AW-1:0]   i_paddr,
  input  wire  [31:0]                      i_pwdata,
  output logic [31:0]                      o_prdata,
  output logic                             o_pready,
  output logic                             o_pslverr,
  input  wire  cfs_pkg::cfs_sample_u       i_in_data,
  input  wire                              i_in_valid,
  output logic                             o_in_ready,
  output cfs_pkg::cfs_sample_u             o_out_data,
  output logic                             o_out_valid,
  input  wire                              i_out_ready
);
  import cfs_pkg::*;

  logic                       advance;
  logic                       accept;
  logic                       freq_wr;
  logic [CFS_PHASE_ACC_W-1:0] freq;
  logic [CFS_SCALE_W-1:0]     scale;
  logic                       arm;
  logic [CFS_PHASE_ACC_W-1:0] tfreq;
  logic [CFS_TIME_W-1:0]      ttime;
  logic [CFS_TIME_W-1:0]      cmd_time;
  logic                       apply;
  logic [CFS_PHASE_ACC_W-1:0] tfreq_q;
  logic                       pending;
  logic                       late_evt;
  logic [CFS_TIME_W-1:0]      count;
  logic                       hit;
  logic                       late;
  logic [CFS_PHASE_W-1:0]     phase;
  logic                       rot_valid;
  logic signed [CFS_CORDIC_W-1:0] rot_i;
  logic signed [CFS_CORDIC_W-1:0] rot_q;

  assign accept     = i_in_valid & advance;
  assign o_in_ready = advance;

  cfs_apb_regs #(.RESET_SCALE(RESET_SCALE)) regs_i (
    .clk, .i_rst_n, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
    .i_pending(pending), .i_late(late_evt), .i_count(count),
    .o_prdata, .o_pready, .o_pslverr,
    .o_freq_wr(freq_wr), .o_freq(freq), .o_scale(scale),
    .o_arm(arm), .o_tfreq(tfreq), .o_ttime(ttime));

  cfs_cmd_sched sched_i (
    .clk, .i_rst_n, .i_arm(arm), .i_tfreq(tfreq), .i_ttime(ttime),
    .i_accept(accept), .i_hit(hit), .i_late(late),
    .o_cmd_time(cmd_time), .o_apply(apply), .o_tfreq_q(tfreq_q),
    .o_pending(pending), .o_late_evt(late_evt));

  cfs_sample_timer timer_i (
    .clk, .i_rst_n, .i_accept(accept), .i_cmd_time(cmd_time),
    .o_count(count), .o_hit(hit), .o_late(late));

  cfs_phase_accum nco_i (
    .clk, .i_rst_n, .i_accept(accept), .i_freq_wr(freq_wr), .i_freq(freq),
    .i_apply(apply), .i_tfreq(tfreq_q), .o_phase(phase));

  cfs_cordic_rotator #(.ITERATIONS(ITERATIONS)) rot_i_inst (
    .clk, .i_rst_n, .i_advance(advance), .i_valid(accept),
    .i_sample(i_in_data), .i_phase(phase),
    .o_valid(rot_valid), .o_i(rot_i), .o_q(rot_q));

  cfs_scale_round scale_i (
    .clk, .i_rst_n, .i_valid(rot_valid), .i_i(rot_i), .i_q(rot_q),
    .i_scale(scale), .i_ready(i_out_ready),
    .o_advance(advance), .o_valid(o_out_valid), .o_data(o_out_data));

endmodule

`default_nettype wire
